/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = an_tb
FILELIST  = an_top.f

OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q '^Simulation passed$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* an_top.f */
logic/an_pkg.sv
logic/lacr_rx_filter.sv
logic/link_timer.sv
logic/an_arbiter.sv
logic/lacr_tx_encoder.sv
logic/an_top.sv
testbench/an_tb.sv

/* logic/an_arbiter.sv */
// ----------------------------------------------------------
// Clause 37 arbitration FSM with ability, ack and consistency
// flags, a watchdog that falls back to abort, and status
// ----------------------------------------------------------
`timescale 1ns/1ps

module an_arbiter #(
   parameter int TIMER_TICKS = 1250000,
   parameter int TIMER_W     = 21
) (
   input  logic               rx_clk,
   input  logic               an_rst,
   input  logic               los,
   input  logic               link_det,
   input  logic               match_ok,
   input  an_pkg::cfg_word_u  lacr_prev,
   input  logic               breaklink_seen,
   input  logic               timer_on,
   input  logic               timer_done,
   output logic               timer_start,
   output logic               filter_hold,
   output logic               send_req,
   output logic               send_ack,
   output logic               send_breaklink,
   output logic               operate,
   output an_pkg::an_status_t an_status
);
   import an_pkg::*;

   // Watchdog runs for eight link timer periods
   localparam int WDOG_TIME = 8 * TIMER_TICKS;
   localparam int WDOG_W    = TIMER_W + 3;

   an_state_e         state;
   an_state_e         n_state;
   cfg_word_u         acked_w;
   cfg_word_u         ability_w;
   logic              abl_match;
   logic              ack_match;
   logic              consistency_match;
   logic              ack_seen;
   logic              timer_idle;
   logic              force_restart;
   logic              wdog_disable;
   logic              wdog_timeout;
   logic [WDOG_W-1:0] wdog_cnt;
   logic              n_operate;
   an_status_t        status_c;

   // Restart on breaklink, loss of signal or watchdog expiry
   // Breaklink is ignored once the watchdog has given up
   assign force_restart = (breaklink_seen & ~wdog_disable) | los | wdog_timeout;

   always_ff @(posedge rx_clk) begin
      if (an_rst || force_restart) begin
         state <= AN_RESTART;
      end else begin
         state <= n_state;
      end
   end

   // Freeze matching while we send breaklink
   assign filter_hold = (state == AN_RESTART);

   // Ability as it should come back once acknowledged
   always_comb begin
      acked_w = lacr_prev;
      acked_w.page.ack = 1'b1;
   end

   // Partner word is an ack seen in ACK state
   assign ack_seen = (state == AN_ACK) && match_ok && lacr_prev.page.ack;

   always_ff @(posedge rx_clk) begin
      if (state == AN_ABILITY && match_ok) begin
         ability_w <= acked_w;
      end
   end

   // Flags start over on every restart
   always_ff @(posedge rx_clk) begin
      if (an_rst || state == AN_RESTART) begin
         abl_match         <= 1'b0;
         ack_match         <= 1'b0;
         consistency_match <= 1'b0;
      end else begin
         if (state == AN_ABILITY && match_ok) begin
            abl_match <= 1'b1;
         end
         if (ack_seen) begin
            ack_match <= 1'b1;
         end
         // Checked on the same edge as the ack so the two agree
         if (ack_seen || ack_match) begin
            consistency_match <= (ability_w.raw == lacr_prev.raw);
         end
      end
   end

   // Restart the timer only once the last run has ended
   assign timer_idle = !timer_on && !timer_done;

   always_comb begin
      n_state        = state;
      timer_start    = 1'b0;
      send_req       = 1'b0;
      send_ack       = 1'b0;
      send_breaklink = 1'b0;
      n_operate      = 1'b0;
      case (state)
         AN_RESTART: begin
            send_req       = 1'b1;
            send_breaklink = 1'b1;
            timer_start    = timer_idle;
            if (timer_done && link_det) begin
               n_state = wdog_disable ? AN_ABORT : AN_ABILITY;
            end
         end
         AN_ABILITY: begin
            send_req = 1'b1;
            if (abl_match) begin
               n_state = AN_ACK;
            end
         end
         AN_ACK: begin
            send_req    = 1'b1;
            send_ack    = 1'b1;
            timer_start = timer_idle;
            if (timer_done && ack_match) begin
               n_state = consistency_match ? AN_IDLE : AN_RESTART;
            end
         end
         AN_IDLE: begin
            // Word still pending in the encoder must carry ack
            send_ack    = 1'b1;
            timer_start = timer_idle;
            if (timer_done) begin
               n_state = AN_LINK_OK;
            end
         end
         AN_LINK_OK: begin
            // Local page keeps the ack of the partner page
            send_ack  = 1'b1;
            n_operate = 1'b1;
         end
         AN_ABORT: begin
            // Give up and run without negotiation
            n_operate = 1'b1;
         end
         default: begin
            n_state = AN_RESTART;
         end
      endcase
   end

   // Watchdog, cleared on forward progress or loss of signal
   always_ff @(posedge rx_clk) begin
      if (an_rst || los || (n_state > state && state != AN_RESTART)) begin
         wdog_cnt     <= '0;
         wdog_disable <= 1'b0;
      end else if (link_det && state != AN_LINK_OK) begin
         if (!wdog_disable) begin
            wdog_cnt <= wdog_cnt + 1'b1;
         end
         if (wdog_timeout) begin
            wdog_disable <= 1'b1;
         end
      end
   end

   // Single event, count parks once disabled
   assign wdog_timeout = !wdog_disable && (wdog_cnt == WDOG_W'(WDOG_TIME));

   always_comb begin
      status_c.abort        = (state == AN_ABORT);
      status_c.ability      = (state == AN_ABILITY);
      status_c.wdog_disable = wdog_disable;
      status_c.remote_fault = lacr_prev.page.rf;
      // Partner lacks full duplex
      status_c.abl_mismatch = abl_match & ~ability_w.page.fd;
      status_c.ack          = (state == AN_ACK);
      status_c.idle         = (state == AN_IDLE);
      status_c.link_ok      = (state == AN_LINK_OK);
   end

   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         operate   <= 1'b0;
         an_status <= '0;
      end else begin
         operate   <= n_operate;
         an_status <= status_c;
      end
   end

   a_operate_state: assert property (
      @(posedge rx_clk) disable iff (an_rst)
      operate |-> $past(state == AN_LINK_OK || state == AN_ABORT)
   );

endmodule

/* logic/an_pkg.sv */
// ----------------------------------------------------------
// Shared types for the 1000BASE-X Clause 37 auto-negotiation
// block. Import into any module that handles config words
// ----------------------------------------------------------
package an_pkg;

   // Base page in Clause 37 bit order, bit 15 first
   typedef struct packed {
      logic       np;      // Next page follows
      logic       ack;     // Partner page seen three times
      // Remote fault
      // 00 ok, 01 offline, 10 link failure, 11 link error
      logic [1:0] rf;
      logic [2:0] rsv_hi;
      // Pause ability
      // 00 none, 01 asym, 10 sym, 11 sym and asym
      logic [1:0] ps;
      logic       hd;      // Half duplex capable
      logic       fd;      // Full duplex capable
      logic [4:0] rsv_lo;
   } ability_t;

   // Same 16 bits seen two ways
   // raw for equality and breaklink checks, page for the fields
   typedef union packed {
      logic [15:0] raw;
      ability_t    page;
   } cfg_word_u;

   // Arbitration states, order matters for the watchdog
   typedef enum logic [2:0] {
      AN_RESTART = 3'd0,
      AN_ABILITY = 3'd1,
      AN_ACK     = 3'd2,
      AN_IDLE    = 3'd3,
      AN_LINK_OK = 3'd4,
      AN_ABORT   = 3'd5
   } an_state_e;

   // Status word, high bit first
   typedef struct packed {
      logic       abort;
      logic       ability;
      logic       wdog_disable;
      logic [1:0] remote_fault;
      logic       abl_mismatch;
      logic       ack;
      logic       idle;
      logic       link_ok;
   } an_status_t;

   // All zero word, restarts the partner after three in a row
   localparam cfg_word_u BREAKLINK_WORD = '0;

endpackage

/* logic/an_top.sv */
// ----------------------------------------------------------
// Clause 37 auto-negotiation top level. Takes decoded config
// words from the PCS receive path, gives the word to transmit
// ----------------------------------------------------------
`timescale 1ns/1ps

module an_top #(
   parameter int TIMER_TICKS = 1250000,
   parameter int TIMER_W     = 21
) (
   input  logic               rx_clk,
   input  logic               an_rst,
   input  logic               los,
   input  an_pkg::cfg_word_u  lacr_in,
   input  logic               lacr_in_stb,
   output an_pkg::cfg_word_u  lacr_out,
   output logic               lacr_send,
   output logic               operate,
   output an_pkg::an_status_t an_status
);
   import an_pkg::*;

   // Filter to arbiter
   logic      link_det;
   logic      match_ok;
   cfg_word_u lacr_prev;
   logic      breaklink_seen;
   logic      filter_hold;
   // Timer handshake
   logic      timer_start;
   logic      timer_on;
   logic      timer_done;
   // Arbiter to encoder
   logic      send_req;
   logic      send_ack;
   logic      send_breaklink;

   lacr_rx_filter u_rx_filter (
      .rx_clk         (rx_clk),
      .an_rst         (an_rst),
      .los            (los),
      .lacr_in        (lacr_in),
      .lacr_in_stb    (lacr_in_stb),
      .filter_hold    (filter_hold),
      .link_det       (link_det),
      .match_ok       (match_ok),
      .lacr_prev      (lacr_prev),
      .breaklink_seen (breaklink_seen)
   );

   link_timer #(
      .TIMER_TICKS (TIMER_TICKS),
      .TIMER_W     (TIMER_W)
   ) u_link_timer (
      .rx_clk      (rx_clk),
      .an_rst      (an_rst),
      .timer_start (timer_start),
      .timer_on    (timer_on),
      .timer_done  (timer_done)
   );

   an_arbiter #(
      .TIMER_TICKS (TIMER_TICKS),
      .TIMER_W     (TIMER_W)
   ) u_arbiter (
      .rx_clk         (rx_clk),
      .an_rst         (an_rst),
      .los            (los),
      .link_det       (link_det),
      .match_ok       (match_ok),
      .lacr_prev      (lacr_prev),
      .breaklink_seen (breaklink_seen),
      .timer_on       (timer_on),
      .timer_done     (timer_done),
      .timer_start    (timer_start),
      .filter_hold    (filter_hold),
      .send_req       (send_req),
      .send_ack       (send_ack),
      .send_breaklink (send_breaklink),
      .operate        (operate),
      .an_status      (an_status)
   );

   lacr_tx_encoder u_tx_encoder (
      .rx_clk         (rx_clk),
      .an_rst         (an_rst),
      .send_req       (send_req),
      .send_ack       (send_ack),
      .send_breaklink (send_breaklink),
      .lacr_out       (lacr_out),
      .lacr_send      (lacr_send)
   );

endmodule

/* logic/lacr_rx_filter.sv */
// ----------------------------------------------------------
// Receive side filter for config words. Detects the link,
// counts matching words and spots breaklink from the partner
// ----------------------------------------------------------
`timescale 1ns/1ps

module lacr_rx_filter (
   input  logic              rx_clk,
   input  logic              an_rst,
   input  logic              los,
   input  an_pkg::cfg_word_u lacr_in,
   input  logic              lacr_in_stb,
   input  logic              filter_hold,
   output logic              link_det,
   output logic              match_ok,
   output an_pkg::cfg_word_u lacr_prev,
   output logic              breaklink_seen
);
   import an_pkg::*;

   cfg_word_u  in_masked;
   cfg_word_u  prev_masked;
   logic       same_word;
   logic       match_pls;
   logic       change_pls;
   logic [2:0] match_cnt;
   logic [1:0] zero_cnt;

   // Any strobe means a partner is out there
   always_ff @(posedge rx_clk) begin
      if (an_rst || los) begin
         link_det <= 1'b0;
      end else if (lacr_in_stb) begin
         link_det <= 1'b1;
      end
   end

   // Ack bit ignored when comparing words
   always_comb begin
      in_masked = lacr_in;
      in_masked.page.ack = 1'b0;
      prev_masked = lacr_prev;
      prev_masked.page.ack = 1'b0;
   end

   assign same_word = (in_masked.raw == prev_masked.raw);

   // Match and change pulses one cycle after the strobe
   // Held off entirely while the arbiter restarts
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         lacr_prev  <= BREAKLINK_WORD;
         match_pls  <= 1'b0;
         change_pls <= 1'b0;
         match_cnt  <= 3'd0;
      end else begin
         if (lacr_in_stb && !filter_hold) begin
            lacr_prev <= lacr_in;
         end
         match_pls  <= lacr_in_stb & ~filter_hold & same_word;
         change_pls <= lacr_in_stb & ~filter_hold & ~same_word;
         // Saturating count of matches in a row
         if (change_pls || breaklink_seen) begin
            match_cnt <= 3'd0;
         end else if (match_pls && match_cnt != 3'd3) begin
            match_cnt <= match_cnt + 3'd1;
         end
      end
   end

   assign match_ok = (match_cnt == 3'd3);

   // Zero words in a row, counted even during restart
   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         zero_cnt <= 2'd0;
      end else if (lacr_in_stb) begin
         if (lacr_in.raw == BREAKLINK_WORD.raw) begin
            if (zero_cnt != 2'd3) begin
               zero_cnt <= zero_cnt + 2'd1;
            end
         end else begin
            zero_cnt <= 2'd0;
         end
      end
   end

   // High from the edge that takes the third zero word
   assign breaklink_seen = (zero_cnt == 2'd3);

   a_match_cnt_range: assert property (
      @(posedge rx_clk) disable iff (an_rst) match_cnt <= 3'd3
   );

endmodule

/* logic/lacr_tx_encoder.sv */
// ----------------------------------------------------------
// Builds and registers the config word for the transmit side
// from the arbiter requests, one cycle behind them
// ----------------------------------------------------------
`timescale 1ns/1ps

module lacr_tx_encoder (
   input  logic              rx_clk,
   input  logic              an_rst,
   input  logic              send_req,
   input  logic              send_ack,
   input  logic              send_breaklink,
   output an_pkg::cfg_word_u lacr_out,
   output logic              lacr_send
);
   import an_pkg::*;

   cfg_word_u page_w;

   // Local page, full duplex only
   // No pause, no remote fault, no next page
   always_comb begin
      page_w = '0;
      page_w.page.fd  = 1'b1;
      page_w.page.ack = send_ack;
   end

   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         lacr_out  <= BREAKLINK_WORD;
         lacr_send <= 1'b0;
      end else begin
         lacr_send <= send_req;
         lacr_out  <= send_breaklink ? BREAKLINK_WORD : page_w;
      end
   end

   a_breaklink_zero: assert property (
      @(posedge rx_clk) disable iff (an_rst)
      $past(send_breaklink) |-> (lacr_out.raw == 16'h0000)
   );

endmodule

/* logic/link_timer.sv */
// ----------------------------------------------------------
// Clause 37 link timer. A start pulse loads the count and a
// done pulse follows TIMER_TICKS cycles later
// ----------------------------------------------------------
`timescale 1ns/1ps

module link_timer #(
   parameter int TIMER_TICKS = 1250000,
   parameter int TIMER_W     = 21
) (
   input  logic rx_clk,
   input  logic an_rst,
   input  logic timer_start,
   output logic timer_on,
   output logic timer_done
);

   logic [TIMER_W-1:0] cnt;

   always_ff @(posedge rx_clk) begin
      if (an_rst) begin
         cnt        <= '0;
         timer_on   <= 1'b0;
         timer_done <= 1'b0;
      end else begin
         timer_done <= 1'b0;
         if (timer_start) begin
            cnt      <= TIMER_W'(TIMER_TICKS);
            timer_on <= 1'b1;
         end else if (timer_on) begin
            cnt <= cnt - 1'b1;
            // Last tick, single cycle done
            if (cnt == TIMER_W'(1)) begin
               timer_done <= 1'b1;
               timer_on   <= 1'b0;
            end
         end
      end
   end

endmodule

/* testbench/an_tb.sv */
// ----------------------------------------------------------
// Testbench for the Clause 37 auto-negotiation top level.
// Plays a table of link partners and checks each outcome
// ----------------------------------------------------------
`timescale 1ns/1ps

module an_tb;
   import an_pkg::*;

   localparam int TICKS    = 16;
   localparam int NUM_ROWS = 7;
   // Budget per table row
   localparam int MAX_CYCLES = NUM_ROWS * (12 * TICKS + 200);

   typedef enum logic [1:0] {
      ACT_NONE,
      ACT_BREAKLINK,
      ACT_LOS
   } action_e;

   typedef struct packed {
      cfg_word_u  ability;
      logic       acks;
      logic       consistent;
      action_e    action;
      logic       exp_operate;
      an_status_t exp_status;
      cfg_word_u  exp_out;
   } scenario_t;

   logic        rx_clk = 1'b0;
   logic        an_rst;
   logic        los;
   cfg_word_u   lacr_in = '0;
   logic        lacr_in_stb = 1'b0;
   cfg_word_u   lacr_out;
   logic        lacr_send;
   logic        operate;
   an_status_t  an_status;

   scenario_t   table_rows [NUM_ROWS];
   string       row_names [NUM_ROWS];
   int          row_count;
   int          row_errors;
   int          pass_count;
   int          fail_count;
   int          cycle_cnt;

   // Partner controls, set per row
   logic        partner_on;
   logic        partner_acks;
   logic        send_zeros;
   cfg_word_u   partner_ability;
   cfg_word_u   partner_ack_word;
   // Partner internal state
   logic        partner_acking;
   int          gap_left;
   logic [15:0] lfsr_state = 16'd4;

   // 100 ns period
   always #50 rx_clk = ~rx_clk;

   an_top #(
      .TIMER_TICKS (TICKS)
   ) dut0 (
      .rx_clk      (rx_clk),
      .an_rst      (an_rst),
      .los         (los),
      .lacr_in     (lacr_in),
      .lacr_in_stb (lacr_in_stb),
      .lacr_out    (lacr_out),
      .lacr_send   (lacr_send),
      .operate     (operate),
      .an_status   (an_status)
   );

   // 16 bit Galois LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 16'hB400;
      end
      return n;
   endfunction

   task automatic take_bit(output logic b);
      b = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
   endtask

   // Ack word of the partner
   // consistent one repeats the ability with ack set
   function automatic cfg_word_u ack_word_for(input cfg_word_u ab, input logic consistent);
      cfg_word_u w;
      w = ab;
      w.page.ack = 1'b1;
      if (!consistent) begin
         // Flips a duplex bit it never offered that way
         w.page.hd = ~w.page.hd;
      end
      return w;
   endfunction

   function automatic an_status_t make_status(input logic abort, input logic wdog,
                                              input logic [1:0] rf, input logic mismatch,
                                              input logic link_ok);
      an_status_t s;
      s = '0;
      s.abort        = abort;
      s.wdog_disable = wdog;
      s.remote_fault = rf;
      s.abl_mismatch = mismatch;
      s.link_ok      = link_ok;
      return s;
   endfunction

   // Partner model, one word then 0 to 3 idle cycles
   always @(negedge rx_clk) begin : partner_model
      logic b_lo;
      logic b_hi;
      if (!partner_on) begin
         lacr_in_stb    = 1'b0;
         partner_acking = 1'b0;
         gap_left       = 0;
      end else begin
         // Ack once the DUT acks, drop back when it sends breaklink
         if (lacr_send && lacr_out.page.ack) begin
            partner_acking = 1'b1;
         end else if (lacr_send && lacr_out.raw == 16'h0000) begin
            partner_acking = 1'b0;
         end
         if (gap_left != 0) begin
            lacr_in_stb = 1'b0;
            gap_left    = gap_left - 1;
         end else begin
            lacr_in_stb = 1'b1;
            if (send_zeros) begin
               lacr_in = BREAKLINK_WORD;
            end else if (partner_acking && partner_acks) begin
               lacr_in = partner_ack_word;
            end else begin
               lacr_in = partner_ability;
            end
            take_bit(b_lo);
            take_bit(b_hi);
            gap_left = 2 * int'(b_hi) + int'(b_lo);
         end
      end
   end

   task automatic check_level(input string test, input string what,
                              input logic exp, input logic act);
      if (act !== exp) begin
         $display("[FAIL] %s %s: expected %b, actual %b", test, what, exp, act);
         row_errors++;
      end
   endtask

   task automatic check_word(input string test, input cfg_word_u exp, input cfg_word_u act);
      if (act.raw !== exp.raw) begin
         $display("[FAIL] %s lacr_out: expected %h, actual %h", test, exp.raw, act.raw);
         row_errors++;
      end
   endtask

   task automatic check_status(input string test, input an_status_t exp,
                               input an_status_t act);
      if (act !== exp) begin
         $display("[FAIL] %s an_status: expected %h, actual %h", test, exp, act);
         row_errors++;
      end
   endtask

   task automatic finish_test(input string name);
      if (row_errors == 0) begin
         pass_count++;
         $display("[PASS] %s", name);
      end else begin
         fail_count++;
         $display("test %s: %0d checks wrong", name, row_errors);
      end
   endtask

   task automatic add_row(input string name, input logic [15:0] ability, input logic acks,
                          input logic consistent, input action_e action,
                          input logic exp_operate, input an_status_t exp_status,
                          input logic [15:0] exp_out);
      scenario_t r;
      r.ability     = ability;
      r.acks        = acks;
      r.consistent  = consistent;
      r.action      = action;
      r.exp_operate = exp_operate;
      r.exp_status  = exp_status;
      r.exp_out     = exp_out;
      table_rows[row_count] = r;
      row_names[row_count]  = name;
      row_count++;
   endtask

   task automatic load_table();
      row_count = 0;
      // fd is bit 5, hd bit 6, rf bits 13 and 12, ack bit 14
      add_row("fd_partner", 16'h0020, 1'b1, 1'b1, ACT_NONE, 1'b1,
              make_status(1'b0, 1'b0, 2'b00, 1'b0, 1'b1), 16'h4020);
      add_row("fd_remote_fault", 16'h2020, 1'b1, 1'b1, ACT_NONE, 1'b1,
              make_status(1'b0, 1'b0, 2'b10, 1'b0, 1'b1), 16'h4020);
      add_row("ack_inconsistent", 16'h0020, 1'b1, 1'b0, ACT_NONE, 1'b0,
              make_status(1'b0, 1'b0, 2'b00, 1'b0, 1'b0), 16'h0000);
      add_row("hd_only", 16'h0040, 1'b1, 1'b1, ACT_NONE, 1'b1,
              make_status(1'b0, 1'b0, 2'b00, 1'b1, 1'b1), 16'h4020);
      add_row("breaklink_restart", 16'h0020, 1'b1, 1'b1, ACT_BREAKLINK, 1'b0,
              make_status(1'b0, 1'b0, 2'b00, 1'b0, 1'b0), 16'h0000);
      add_row("los_restart", 16'h0020, 1'b1, 1'b1, ACT_LOS, 1'b0,
              make_status(1'b0, 1'b0, 2'b00, 1'b0, 1'b0), 16'h0000);
      // Never acks, so watchdog gives up and runs anyway
      add_row("watchdog_abort", 16'h0020, 1'b0, 1'b1, ACT_NONE, 1'b1,
              make_status(1'b1, 1'b1, 2'b00, 1'b0, 1'b0), 16'h0020);
   endtask

   task automatic apply_reset();
      an_rst = 1'b1;
      repeat (8) @(negedge rx_clk);
      an_rst = 1'b0;
   endtask

   task automatic wait_operate(input logic level);
      while (operate !== level) begin
         @(negedge rx_clk);
      end
   endtask

   task automatic run_row(input string name, input scenario_t row);
      logic seen_ack;
      row_errors       = 0;
      partner_on       = 1'b0;
      send_zeros       = 1'b0;
      partner_acks     = row.acks;
      partner_ability  = row.ability;
      partner_ack_word = ack_word_for(row.ability, row.consistent);
      apply_reset();
      partner_on = 1'b1;
      if (row.action != ACT_NONE) begin
         // Link up first, then break it
         wait_operate(1'b1);
         if (row.action == ACT_BREAKLINK) begin
            send_zeros = 1'b1;
         end else begin
            los = 1'b1;
            @(negedge rx_clk);
            los = 1'b0;
         end
         wait_operate(1'b0);
      end else if (row.exp_operate) begin
         wait_operate(1'b1);
      end else begin
         // DUT acks, then falls back to breaklink
         seen_ack = 1'b0;
         while (!(seen_ack && lacr_send && lacr_out.raw == 16'h0000)) begin
            @(negedge rx_clk);
            if (lacr_send && lacr_out.page.ack) begin
               seen_ack = 1'b1;
            end
         end
      end
      check_level(name, "operate", row.exp_operate, operate);
      // Words go out only while negotiating
      check_level(name, "lacr_send", !row.exp_operate, lacr_send);
      check_status(name, row.exp_status, an_status);
      check_word(name, row.exp_out, lacr_out);
      send_zeros = 1'b0;
      finish_test(name);
   endtask

   initial begin : main_seq
      an_rst           = 1'b1;
      los              = 1'b0;
      partner_on       = 1'b0;
      partner_acks     = 1'b0;
      send_zeros       = 1'b0;
      partner_ability  = '0;
      partner_ack_word = '0;
      pass_count       = 0;
      fail_count       = 0;
      load_table();

      // Idle after reset, breaklink one cycle on
      row_errors = 0;
      apply_reset();
      check_level("reset", "operate", 1'b0, operate);
      check_level("reset", "lacr_send", 1'b0, lacr_send);
      @(negedge rx_clk);
      check_level("reset", "operate", 1'b0, operate);
      check_level("reset", "lacr_send", 1'b1, lacr_send);
      check_word("reset", BREAKLINK_WORD, lacr_out);
      check_status("reset", '0, an_status);
      finish_test("reset");

      for (int i = 0; i < row_count; i++) begin
         run_row(row_names[i], table_rows[i]);
      end

      $display("tests %0d, passed %0d, failed %0d",
               pass_count + fail_count, pass_count, fail_count);
      if (fail_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // Run limit in clock cycles
   initial begin : timeout_guard
      cycle_cnt = 0;
      while (cycle_cnt < MAX_CYCLES) begin
         @(posedge rx_clk);
         cycle_cnt++;
      end
      $display("Timeout: the DUT gave no result within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
   end

endmodule
